// File: include/video_macros.svh
// ----------------------------------------------------------------------
// video macros: frame geometry, pixel pipeline lead, register numbers
// ----------------------------------------------------------------------
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal geometry in pixel clocks
`define VID_H_VISIBLE       16
`define VID_H_FRONT         2
`define VID_H_SYNC          3
`define VID_H_BACK          3
`define VID_H_TOTAL         (`VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)

// vertical geometry in lines
`define VID_V_VISIBLE       6
`define VID_V_FRONT         1
`define VID_V_SYNC          2
`define VID_V_BACK          1
`define VID_V_TOTAL         (`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

`define VID_PF_LEAD         2           // counter value to color out, in clocks
`define VID_BORDER_RESET    8'h08       // dark grey border out of reset

// register numbers
`define XR_VID_CTRL         4'd0        // border color, low byte
`define XR_VID_INTR         4'd1        // write-only, force video interrupt
`define XR_VID_LEFT         4'd2
`define XR_VID_RIGHT        4'd3
`define XR_SCANLINE         4'd4        // read-only
`define XR_VID_HSIZE        4'd5        // read-only
`define XR_VID_VSIZE        4'd6        // read-only
`define XR_PF_GFX_CTRL      4'd8        // colorbase [15:8], blank [7]
`define XR_PF_DISP_ADDR     4'd9
`define XR_PF_LINE_LEN      4'd10
`define XR_PF_LINE_ADDR     4'd11       // write-only, next line override

`endif

// File: hw/video_pkg.sv
// ----------------------------------------------------------------------
// video package: shared data types of the video generator
// ----------------------------------------------------------------------
`include "video_macros.svh"

package video_pkg;

typedef logic [15:0]    word_t;         // vram word, register data
typedef logic [15:0]    addr_t;         // vram word address
typedef logic [7:0]     color_t;        // palette index
typedef logic [3:0]     reg_num_t;      // register number

// counters sized from the frame totals
typedef logic [$clog2(`VID_H_TOTAL)-1:0] hres_t;
typedef logic [$clog2(`VID_V_TOTAL)-1:0] vres_t;

// sync/blank bundle delayed to line up with color out
typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       h_blank;
    logic       v_blank;
    logic       dv_de;
} sync_bits_t;

endpackage

// File: hw/video_ifs.sv
// ----------------------------------------------------------------------
// video interfaces: raster timing bus and playfield configuration bus
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "video_macros.svh"

// undelayed raster counters and strobes
interface vid_timing_if import video_pkg::*; ();
    hres_t      h_count;
    vres_t      v_count;
    logic       h_visible;              // h_count inside visible width
    logic       v_visible;              // v_count inside visible height
    logic       end_of_line;            // last h_count of any line
    logic       end_of_frame;           // last count of last line
    logic       end_of_visible;         // last count of last visible line

    modport source (output h_count, v_count, h_visible, v_visible,
                    output end_of_line, end_of_frame, end_of_visible);
    modport sink   (input h_count, v_count, h_visible, v_visible,
                    input end_of_line, end_of_frame, end_of_visible);
endinterface

// register-held playfield setup
interface pf_cfg_if import video_pkg::*; ();
    logic       pf_blank;
    color_t     colorbase;              // xor onto bitmap pixels
    color_t     border_color;
    hres_t      vid_left;               // first windowed pixel
    hres_t      vid_right;              // one past last windowed pixel
    addr_t      start_addr;             // frame start in vram
    word_t      line_len;               // words per line
    addr_t      line_set_addr;
    logic       line_set;               // one clock, on line addr write

    modport regs (output pf_blank, colorbase, border_color, vid_left, vid_right,
                  output start_addr, line_len, line_set_addr, line_set);
    modport pf   (input pf_blank, colorbase, border_color, vid_left, vid_right,
                  input start_addr, line_len, line_set_addr, line_set);
endinterface

// File: hw/video_timing.sv
// ----------------------------------------------------------------------
// video timing: raster counters, region decode, delayed sync and blank
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps
`include "video_macros.svh"

module video_timing import video_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    vid_timing_if.source tmg,               // undelayed counters out
    output      logic   hsync_o,
    output      logic   vsync_o,
    output      logic   h_blank_o,
    output      logic   v_blank_o,
    output      logic   dv_de_o
);

localparam hres_t H_LAST        = hres_t'(`VID_H_TOTAL - 1);
localparam vres_t V_LAST        = vres_t'(`VID_V_TOTAL - 1);
localparam hres_t H_SYNC_BEGIN  = hres_t'(`VID_H_VISIBLE + `VID_H_FRONT);
localparam hres_t H_SYNC_END    = hres_t'(`VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC);
localparam vres_t V_SYNC_BEGIN  = vres_t'(`VID_V_VISIBLE + `VID_V_FRONT);
localparam vres_t V_SYNC_END    = vres_t'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC);

// idle output state, blanked with sync released
localparam sync_bits_t SYNC_IDLE = '{hsync: 1'b0, vsync: 1'b0,
                                     h_blank: 1'b1, v_blank: 1'b1, dv_de: 1'b0};

hres_t      h_count;
vres_t      v_count;
logic       h_visible;
logic       v_visible;
logic       end_of_line;
sync_bits_t sync_now;                       // decoded from current counts
sync_bits_t sync_pipe [`VID_PF_LEAD];       // [0] newest

// region decode
always_comb begin
    h_visible       = (h_count < hres_t'(`VID_H_VISIBLE));
    v_visible       = (v_count < vres_t'(`VID_V_VISIBLE));
    end_of_line     = (h_count == H_LAST);

    sync_now.hsync   = (h_count >= H_SYNC_BEGIN) && (h_count < H_SYNC_END);
    sync_now.vsync   = (v_count >= V_SYNC_BEGIN) && (v_count < V_SYNC_END);
    sync_now.h_blank = ~h_visible;
    sync_now.v_blank = ~v_visible;
    sync_now.dv_de   = h_visible & v_visible;
end

assign tmg.h_count          = h_count;
assign tmg.v_count          = v_count;
assign tmg.h_visible        = h_visible;
assign tmg.v_visible        = v_visible;
assign tmg.end_of_line      = end_of_line;
assign tmg.end_of_frame     = end_of_line && (v_count == V_LAST);
assign tmg.end_of_visible   = end_of_line && (v_count == vres_t'(`VID_V_VISIBLE - 1));

// pixel and line counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count     <= '0;
        v_count     <= '0;
    end else if (end_of_line) begin
        h_count     <= '0;
        v_count     <= (v_count == V_LAST) ? '0 : v_count + 1'b1;   // wrap at frame end
    end else begin
        h_count     <= h_count + 1'b1;
    end
end

// delay line so sync/blank match the playfield color pipe
always_ff @(posedge clk) begin
    if (reset_i) begin
        for (int i = 0; i < `VID_PF_LEAD; i++) begin
            sync_pipe[i] <= SYNC_IDLE;
        end
    end else begin
        sync_pipe[0] <= sync_now;
        for (int i = 1; i < `VID_PF_LEAD; i++) begin
            sync_pipe[i] <= sync_pipe[i-1];
        end
    end
end

assign hsync_o      = sync_pipe[`VID_PF_LEAD-1].hsync;
assign vsync_o      = sync_pipe[`VID_PF_LEAD-1].vsync;
assign h_blank_o    = sync_pipe[`VID_PF_LEAD-1].h_blank;
assign v_blank_o    = sync_pipe[`VID_PF_LEAD-1].v_blank;
assign dv_de_o      = sync_pipe[`VID_PF_LEAD-1].dv_de;

endmodule
`default_nettype wire

// File: hw/video_regs.sv
// ----------------------------------------------------------------------
// video registers: write decode, registered readback, video interrupt
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps
`include "video_macros.svh"

module video_regs import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,           // write strobe
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output      word_t      reg_data_o,         // one clock after reg_num_i
    output      logic       video_intr_o,       // one clock pulse
    vid_timing_if.sink      tmg,
    pf_cfg_if.regs          cfg
);

localparam int HW = $bits(hres_t);

word_t      rd_word;                            // readback mux out
logic       intr_wr;                            // forced interrupt write

assign intr_wr = reg_wr_i && (reg_num_i == `XR_VID_INTR);

// register writes
always_ff @(posedge clk) begin
    if (reset_i) begin
        video_intr_o        <= 1'b0;
        cfg.border_color    <= `VID_BORDER_RESET;
        cfg.vid_left        <= '0;
        cfg.vid_right       <= hres_t'(`VID_H_VISIBLE);     // full width window
        cfg.pf_blank        <= 1'b1;                        // playfield starts off
        cfg.colorbase       <= '0;
        cfg.start_addr      <= '0;
        cfg.line_len        <= word_t'(`VID_H_VISIBLE / 2); // two pixels per word
        cfg.line_set_addr   <= '0;
        cfg.line_set        <= 1'b0;
    end else begin
        cfg.line_set        <= 1'b0;                        // strobe
        video_intr_o        <= tmg.end_of_visible | intr_wr;

        if (reg_wr_i) begin
            case (reg_num_i)
                `XR_VID_CTRL: begin
                    cfg.border_color    <= reg_data_i[7:0];
                end
                `XR_VID_LEFT: begin
                    cfg.vid_left        <= reg_data_i[HW-1:0];
                end
                `XR_VID_RIGHT: begin
                    cfg.vid_right       <= reg_data_i[HW-1:0];
                end
                `XR_PF_GFX_CTRL: begin
                    cfg.colorbase       <= reg_data_i[15:8];
                    cfg.pf_blank        <= reg_data_i[7];
                end
                `XR_PF_DISP_ADDR: begin
                    cfg.start_addr      <= reg_data_i;
                end
                `XR_PF_LINE_LEN: begin
                    cfg.line_len        <= reg_data_i;
                end
                `XR_PF_LINE_ADDR: begin
                    cfg.line_set_addr   <= reg_data_i;
                    cfg.line_set        <= 1'b1;            // playfield picks up at line end
                end
                default: begin
                    // intr handled above, read-only and unused ignore writes
                end
            endcase
        end
    end
end

// readback select, fields in write layout
always_comb begin
    case (reg_num_i)
        `XR_VID_CTRL:       rd_word = {8'h00, cfg.border_color};
        `XR_VID_LEFT:       rd_word = word_t'(cfg.vid_left);
        `XR_VID_RIGHT:      rd_word = word_t'(cfg.vid_right);
        `XR_SCANLINE:       rd_word = word_t'(tmg.v_count);     // live line number
        `XR_VID_HSIZE:      rd_word = word_t'(`VID_H_VISIBLE);
        `XR_VID_VSIZE:      rd_word = word_t'(`VID_V_VISIBLE);
        `XR_PF_GFX_CTRL:    rd_word = {cfg.colorbase, cfg.pf_blank, 7'b0};
        `XR_PF_DISP_ADDR:   rd_word = cfg.start_addr;
        `XR_PF_LINE_LEN:    rd_word = cfg.line_len;
        default:            rd_word = '0;                       // write-only and unused
    endcase
end

// fixed one clock read latency
always_ff @(posedge clk) begin
    reg_data_o  <= rd_word;
end

endmodule
`default_nettype wire

// File: hw/video_bitmap_pf.sv
// ----------------------------------------------------------------------
// bitmap playfield: line address tracking, vram fetch, 8 bpp pixel out
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps
`include "video_macros.svh"

module video_bitmap_pf import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    vid_timing_if.sink      tmg,
    pf_cfg_if.pf            cfg,
    output      logic       vram_sel_o,         // read request
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,        // valid one clock after request
    output      color_t     color_index_o       // VID_PF_LEAD after counters
);

addr_t      line_addr;                  // first word of current line
logic       line_set_pend;              // override seen since last line end
logic       fetch_d;                    // request went out last clock
word_t      word_hold;                  // keeps word for the odd pixel
logic       pix_odd;                    // stage 1 pixel parity
logic       pix_show;                   // stage 1 bitmap (not border)
logic       in_window;
color_t     pix_raw;

// line start address, frame start then line_len steps
always_ff @(posedge clk) begin
    if (reset_i) begin
        line_addr       <= '0;
        line_set_pend   <= 1'b0;
    end else begin
        if (cfg.line_set) begin
            line_set_pend   <= 1'b1;
        end
        if (tmg.end_of_frame) begin
            line_addr       <= cfg.start_addr;      // frame start wins
        end else if (tmg.end_of_line) begin
            if (line_set_pend || cfg.line_set) begin
                line_addr   <= cfg.line_set_addr;   // one-shot override
            end else if (tmg.v_visible) begin
                line_addr   <= line_addr + cfg.line_len;
            end
        end
        if (tmg.end_of_line) begin
            line_set_pend   <= 1'b0;                // consumed or dropped at line end
        end
    end
end

// one word per pixel pair, requested on even counts
assign vram_sel_o   = tmg.h_visible && tmg.v_visible && !tmg.h_count[0] && !cfg.pf_blank;
assign vram_addr_o  = line_addr + addr_t'(tmg.h_count >> 1);

assign in_window    = (tmg.h_count >= cfg.vid_left) && (tmg.h_count < cfg.vid_right);

// stage 1, pixel attributes from the counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        fetch_d     <= 1'b0;
        pix_odd     <= 1'b0;
        pix_show    <= 1'b0;
    end else begin
        fetch_d     <= vram_sel_o;
        pix_odd     <= tmg.h_count[0];
        pix_show    <= tmg.h_visible && tmg.v_visible && in_window && !cfg.pf_blank;
    end
end

// word arrives with even pixel, odd pixel needs it a clock later
always_ff @(posedge clk) begin
    if (fetch_d) begin
        word_hold   <= vram_data_i;
    end
end

assign pix_raw = pix_odd ? word_hold[7:0] : vram_data_i[15:8];     // high byte first

// stage 2, color out
always_ff @(posedge clk) begin
    color_index_o   <= pix_show ? (pix_raw ^ cfg.colorbase) : cfg.border_color;
end

endmodule
`default_nettype wire

// File: hw/video_gen.sv
// ----------------------------------------------------------------------
// video generator top: timing, registers and bitmap playfield
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps
`include "video_macros.svh"

module video_gen import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    // register port
    input  wire logic       reg_wr_i,           // write strobe
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output      word_t      reg_data_o,         // registered readback
    output      logic       video_intr_o,
    // vram read port, no stall
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,
    // video out, all aligned to color_index_o
    output      color_t     color_index_o,
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       h_blank_o,
    output      logic       v_blank_o,
    output      logic       dv_de_o
);

vid_timing_if   tmg_if ();          // raster counters and strobes
pf_cfg_if       cfg_if ();          // playfield setup from registers

video_timing video_timing (
    .clk            (clk),
    .reset_i        (reset_i),
    .tmg            (tmg_if.source),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o),
    .dv_de_o        (dv_de_o)
);

video_regs video_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_i       (reg_wr_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .reg_data_o     (reg_data_o),
    .video_intr_o   (video_intr_o),
    .tmg            (tmg_if.sink),
    .cfg            (cfg_if.regs)
);

video_bitmap_pf video_pf (
    .clk            (clk),
    .reset_i        (reset_i),
    .tmg            (tmg_if.sink),
    .cfg            (cfg_if.pf),
    .vram_sel_o     (vram_sel_o),
    .vram_addr_o    (vram_addr_o),
    .vram_data_i    (vram_data_i),
    .color_index_o  (color_index_o)
);

endmodule
`default_nettype wire

// File: test/video_gen_chk.sv
// ----------------------------------------------------------------------
// video checker for sync width, interrupt pulse and blanked fetch
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "video_macros.svh"

module video_gen_chk import video_pkg::*; (
    input logic     clk,
    input logic     reset_i,
    input logic     hsync_i,
    input logic     intr_i,
    input logic     vram_sel_i,
    input logic     reg_wr_i,               // register port as driven
    input reg_num_t reg_num_i,
    input word_t    reg_data_i
);

logic       blank_q;                        // blank bit as last written

always_ff @(posedge clk) begin
    if (reset_i) begin
        blank_q <= 1'b1;                    // playfield blanked out of reset
    end else if (reg_wr_i && (reg_num_i == `XR_PF_GFX_CTRL)) begin
        blank_q <= reg_data_i[7];
    end
end

hsync_width: assert property (@(posedge clk) disable iff (reset_i)
    $rose(hsync_i) |-> hsync_i [*`VID_H_SYNC] ##1 !hsync_i)
    else $error("hsync pulse width differs from sync length");

intr_single: assert property (@(posedge clk) disable iff (reset_i)
    intr_i |=> !intr_i)                     // one clock pulse only
    else $error("video interrupt high on two clocks in a row");

blank_no_fetch: assert property (@(posedge clk) disable iff (reset_i)
    blank_q |-> !vram_sel_i)
    else $error("vram request while playfield blanked");

endmodule

bind video_gen video_gen_chk chk (
    .clk(clk), .reset_i(reset_i), .hsync_i(hsync_o), .intr_i(video_intr_o),
    .vram_sel_i(vram_sel_o), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i)
);

// File: test/video_gen_tb.sv
// ----------------------------------------------------------------------
// video generator testbench with register table, vram model and pixel checker
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "video_macros.svh"

module video_gen_tb import video_pkg::*; ();

typedef struct packed {
    logic       wr;                     // 1 write, 0 read and compare
    reg_num_t   num;
    word_t      data;
    word_t      exp;
} reg_op_t;

logic clk, reset_i, reg_wr_i, video_intr_o, vram_sel_o;
logic hsync_o, vsync_o, h_blank_o, v_blank_o, dv_de_o;
reg_num_t   reg_num_i;
word_t      reg_data_i, reg_data_o, vram_data_i;
addr_t      vram_addr_o;
color_t     color_index_o;

word_t      vram [256];                 // lfsr filled vram contents
int         errors, checks, timeouts;
int         x, y, frames;               // output raster position
int         de_cnt, hs_cnt, hs_vis_cnt, intr_cnt, hb_cnt;
int         last_de, last_hs, last_hs_vis, last_intr, last_hb;     // previous full frame
logic       prev_de, prev_hs, prev_vs, check_en;
// expected playfield setup tracking every register write
color_t     border, cb;
int         left, right;
logic       blank, ovr_pend;
addr_t      start, len, lbase, ovr_addr;

reg_op_t reg_table [22] = '{
    '{1'b0, `XR_VID_CTRL,     16'h0000, 16'h0008},  // reset values first
    '{1'b0, `XR_PF_GFX_CTRL,  16'h0000, 16'h0080},
    '{1'b0, `XR_VID_HSIZE,    16'h0000, 16'h0010},
    '{1'b0, `XR_VID_VSIZE,    16'h0000, 16'h0006},
    '{1'b0, `XR_VID_LEFT,     16'h0000, 16'h0000},
    '{1'b0, `XR_VID_RIGHT,    16'h0000, 16'h0010},
    '{1'b0, `XR_PF_LINE_LEN,  16'h0000, 16'h0008},
    '{1'b0, `XR_PF_LINE_ADDR, 16'h0000, 16'h0000},  // write-only
    '{1'b0, `XR_VID_INTR,     16'h0000, 16'h0000},
    '{1'b0, 4'd7,             16'h0000, 16'h0000},  // unused
    '{1'b1, `XR_VID_CTRL,     16'h0033, 16'h0000},
    '{1'b0, `XR_VID_CTRL,     16'h0000, 16'h0033},
    '{1'b1, `XR_VID_LEFT,     16'h0002, 16'h0000},
    '{1'b0, `XR_VID_LEFT,     16'h0000, 16'h0002},
    '{1'b1, `XR_VID_RIGHT,    16'h000e, 16'h0000},
    '{1'b0, `XR_VID_RIGHT,    16'h0000, 16'h000e},
    '{1'b1, `XR_PF_DISP_ADDR, 16'h0020, 16'h0000},
    '{1'b0, `XR_PF_DISP_ADDR, 16'h0000, 16'h0020},
    '{1'b1, `XR_PF_LINE_LEN,  16'h000a, 16'h0000},
    '{1'b0, `XR_PF_LINE_LEN,  16'h0000, 16'h000a},
    '{1'b1, `XR_PF_GFX_CTRL,  16'h5a80, 16'h0000},  // colorbase set while still blanked
    '{1'b0, `XR_PF_GFX_CTRL,  16'h0000, 16'h5a80}
};

video_gen UUT (.*);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// galois lfsr stepped once per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
endfunction

// vram answers one clock after the request
always @(posedge clk) begin
    if (vram_sel_o) begin
        vram_data_i <= vram[vram_addr_o[7:0]];
    end
end

// output monitor for pixel compare and frame statistics
always @(negedge clk) begin
    color_t exp_pix;
    word_t  w;
    if (!reset_i) begin
        if (dv_de_o) begin
            w = vram[8'(lbase + addr_t'(x / 2))];
            if (blank || x < left || x >= right) begin
                exp_pix = border;                       // outside window shows border without xor
            end else begin
                exp_pix = ((x % 2) == 0) ? (w[15:8] ^ cb) : (w[7:0] ^ cb);
            end
            if (check_en) begin
                checks++;
                assert (color_index_o == exp_pix) else begin
                    errors++;
                    $display("ERROR %0t: pixel x=%0d y=%0d got %h expected %h",
                             $time, x, y, color_index_o, exp_pix);
                end
            end
            x++;
        end else if (prev_de) begin                     // line run just ended
            x = 0;
            y++;
            lbase = ovr_pend ? ovr_addr : lbase + len;
            ovr_pend = 1'b0;
        end
        if (v_blank_o) begin
            y = 0;
            lbase = start;
        end
        if (check_en && blank) begin
            checks++;
            assert (!vram_sel_o) else begin
                errors++;
                $display("ERROR %0t: vram request while playfield blanked", $time);
            end
        end
        de_cnt += dv_de_o;
        intr_cnt += video_intr_o;
        hb_cnt += !h_blank_o;
        if (hsync_o && !prev_hs) begin
            hs_cnt++;
            hs_vis_cnt += !v_blank_o;
        end
        if (vsync_o && !prev_vs) begin                  // frame window edge
            last_de = de_cnt;
            last_hs = hs_cnt;
            last_hs_vis = hs_vis_cnt;
            last_intr = intr_cnt;
            last_hb = hb_cnt;
            de_cnt = 0;
            hs_cnt = 0;
            hs_vis_cnt = 0;
            intr_cnt = 0;
            hb_cnt = 0;
            frames++;
        end
        prev_de = dv_de_o;
        prev_hs = hsync_o;
        prev_vs = vsync_o;
    end
end

task automatic write_reg(input reg_num_t num, input word_t data);
    @(posedge clk);
    reg_wr_i    <= 1'b1;
    reg_num_i   <= num;
    reg_data_i  <= data;
    @(posedge clk);
    reg_wr_i    <= 1'b0;
    case (num)
        `XR_VID_CTRL:       border = data[7:0];
        `XR_VID_LEFT:       left = data[4:0];
        `XR_VID_RIGHT:      right = data[4:0];
        `XR_PF_GFX_CTRL:    {cb, blank} = data[15:7];
        `XR_PF_DISP_ADDR:   start = data;
        `XR_PF_LINE_LEN:    len = data;
        default:            ;
    endcase
endtask

task automatic read_reg(input reg_num_t num, output word_t data);
    @(posedge clk);
    reg_num_i   <= num;
    @(posedge clk);
    @(negedge clk);                             // readback settled
    data = reg_data_o;
endtask

// waits for the next vsync rise
task automatic wait_frame();
    int f0;
    int n;
    f0 = frames;
    n = 0;
    while (frames == f0 && n < 1000) begin
        @(posedge clk);
        n++;
    end
    if (frames == f0) begin
        timeouts++;
        $display("timeout: no vsync edge within 1000 clocks");
    end
endtask

task automatic wait_line(input int line);
    int n;
    n = 0;
    while (!(dv_de_o && y == line) && n < 1000) begin
        @(posedge clk);
        n++;
    end
    if (n >= 1000) begin
        timeouts++;
        $display("timeout: display line %0d never started", line);
    end
endtask

task automatic check_frame_counts(input int intr_exp);
    checks++;
    assert (last_de == `VID_H_VISIBLE * `VID_V_VISIBLE && last_hs == `VID_V_TOTAL &&
            last_hs_vis == `VID_V_VISIBLE && last_intr == intr_exp &&
            last_hb == `VID_H_VISIBLE * `VID_V_TOTAL) else begin
        errors++;
        $display("ERROR %0t: frame counts de=%0d hsync=%0d visible hsync=%0d intr=%0d hvis=%0d",
                 $time, last_de, last_hs, last_hs_vis, last_intr, last_hb);
    end
endtask

initial begin
    logic [31:0] seed;
    word_t rd;
    {errors, checks, timeouts, x, y, frames} = '0;
    {de_cnt, hs_cnt, hs_vis_cnt, intr_cnt, hb_cnt} = '0;
    {prev_de, prev_hs, prev_vs, check_en, ovr_pend} = '0;
    border = `VID_BORDER_RESET;
    cb = 8'h00;
    left = 0;
    right = `VID_H_VISIBLE;
    blank = 1'b1;
    {start, len, lbase, ovr_addr} = {16'h0, 16'(`VID_H_VISIBLE / 2), 16'h0, 16'h0};
    seed = 32'h1190_8fa7;
    for (int a = 0; a < 256; a++) begin
        for (int b = 0; b < 16; b++) begin
            seed = lfsr_next(seed);
            vram[a][b] = seed[0];
        end
    end
    reset_i = 1'b1;
    {reg_wr_i, reg_num_i, reg_data_i, vram_data_i} = '0;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;

    foreach (reg_table[i]) begin
        if (reg_table[i].wr) begin
            write_reg(reg_table[i].num, reg_table[i].data);
        end else begin
            read_reg(reg_table[i].num, rd);
            checks++;
            assert (rd == reg_table[i].exp) else begin
                errors++;
                $display("ERROR %0t: register %0d read %h expected %h",
                         $time, reg_table[i].num, rd, reg_table[i].exp);
            end
        end
    end

    wait_frame();                               // blanked frame shows border only
    check_en = 1'b1;
    wait_frame();
    wait_frame();
    check_frame_counts(1);
    write_reg(`XR_PF_GFX_CTRL, 16'h5a00);       // unblank in vertical blank
    wait_frame();
    wait_frame();
    check_frame_counts(1);
    wait_line(2);                               // override lands on line 3
    ovr_addr = 16'h0080;
    ovr_pend = 1'b1;
    write_reg(`XR_PF_LINE_ADDR, 16'h0080);
    wait_frame();
    write_reg(`XR_VID_INTR, 16'h0000);          // second pulse this frame
    wait_frame();
    check_frame_counts(2);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

// File: sources.f
+incdir+include
hw/video_pkg.sv
hw/video_ifs.sv
hw/video_timing.sv
hw/video_regs.sv
hw/video_bitmap_pf.sv
hw/video_gen.sv
test/video_gen_chk.sv
test/video_gen_tb.sv
